//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int LINE_COUNT     = 128;
    localparam int INDEX_W        = 7;
    localparam int TAG_W          = 21;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 128;
    localparam int ENTRY_W        = 149;
    localparam int BEAT_W         = $clog2(WORDS_PER_LINE);

    // controller states
    localparam int          STATE_W   = 2;
    localparam logic [1:0]  ST_IDLE   = 2'd0;
    localparam logic [1:0]  ST_LOOKUP = 2'd1;
    localparam logic [1:0]  ST_FILL   = 2'd2;

    // one fetch address, seen as a whole word or split into cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
            logic [BEAT_W-1:0]  word;
            logic [1:0]         byte_sel;
        } f;
    } fetch_addr_u;

endpackage

`default_nettype wire

//--- design/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,

    input  logic [31:0]         fetch_addr_i,
    input  logic                stall_i,
    output logic [WORD_W-1:0]   instr_o,
    output logic                instr_valid_o,

    input  logic                mem_ready_i,
    output logic                mem_req_o,
    output logic [31:0]         mem_addr_o,
    input  logic                mem_rvalid_i,
    input  logic [WORD_W-1:0]   mem_rdata_i
);

    logic                   ram_en;
    logic                   ram_we;
    logic [INDEX_W-1:0]     ram_index;
    logic [ENTRY_W-1:0]     ram_wdata;
    logic [ENTRY_W-1:0]     ram_rdata;

    logic                   fill_start;
    logic [31:0]            fill_addr;
    logic                   fill_done;
    logic [LINE_W-1:0]      fill_line;

    icache_ctrl i_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fetch_addr_i   (fetch_addr_i),
        .stall_i        (stall_i),
        .instr_o        (instr_o),
        .instr_valid_o  (instr_valid_o),
        .ram_en_o       (ram_en),
        .ram_we_o       (ram_we),
        .ram_index_o    (ram_index),
        .ram_wdata_o    (ram_wdata),
        .ram_rdata_i    (ram_rdata),
        .fill_start_o   (fill_start),
        .fill_addr_o    (fill_addr),
        .fill_done_i    (fill_done),
        .fill_line_i    (fill_line)
    );

    icache_line_ram i_ram (
        .clk_i          (clk_i),
        .en_i           (ram_en),
        .we_i           (ram_we),
        .index_i        (ram_index),
        .wdata_i        (ram_wdata),
        .rdata_o        (ram_rdata)
    );

    line_fill_unit i_fill (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fill_start_i   (fill_start),
        .fill_addr_i    (fill_addr),
        .fill_done_o    (fill_done),
        .fill_line_o    (fill_line),
        .mem_ready_i    (mem_ready_i),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i)
    );

endmodule

`default_nettype wire

//--- design/line_fill_unit.sv
`timescale 1ns/1ps
`default_nettype none

module line_fill_unit import icache_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,

    input  logic                fill_start_i,
    input  logic [31:0]         fill_addr_i,
    output logic                fill_done_o,
    output logic [LINE_W-1:0]   fill_line_o,

    input  logic                mem_ready_i,
    output logic                mem_req_o,
    output logic [31:0]         mem_addr_o,
    input  logic                mem_rvalid_i,
    input  logic [WORD_W-1:0]   mem_rdata_i
);

    fetch_addr_u        req_addr;

    logic               busy_r;
    logic               pending_r;
    logic               outstanding_r;
    logic [BEAT_W-1:0]  beat_cnt_r;
    logic               last_beat;
    logic [31:0]        line_addr_r;
    logic [LINE_W-1:0]  line_q;

    assign req_addr.raw = fill_addr_i;

    // request leaves as soon as memory can take it
    assign mem_req_o   = pending_r && mem_ready_i;
    assign mem_addr_o  = line_addr_r;
    assign fill_line_o = line_q;

    assign last_beat = mem_rvalid_i && (beat_cnt_r == BEAT_W'(WORDS_PER_LINE - 1));

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            busy_r        <= 1'b0;
            pending_r     <= 1'b0;
            outstanding_r <= 1'b0;
            beat_cnt_r    <= '0;
            fill_done_o   <= 1'b0;
        end else begin
            fill_done_o <= last_beat;

            if (fill_start_i && !busy_r) begin
                busy_r    <= 1'b1;
                pending_r <= 1'b1;
            end else if (last_beat) begin
                busy_r <= 1'b0;
            end

            if (mem_req_o) begin
                pending_r     <= 1'b0;
                outstanding_r <= 1'b1;
            end else if (last_beat) begin
                outstanding_r <= 1'b0;
            end

            if (mem_rvalid_i) begin
                beat_cnt_r <= beat_cnt_r + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_start_i && !busy_r) begin
            line_addr_r <= {req_addr.f.tag, req_addr.f.index, 4'b0000};
        end
        // beats arrive in ascending word order
        if (mem_rvalid_i) begin
            line_q[beat_cnt_r * WORD_W +: WORD_W] <= mem_rdata_i;
        end
    end

    a_rvalid_needs_request: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        mem_rvalid_i |-> outstanding_r
    );

    a_no_start_while_busy: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        fill_start_i |-> !busy_r
    );

endmodule

`default_nettype wire

//--- flist.f
common/icache_pkg.sv
icache/icache_line_ram.sv
icache/icache_ctrl.sv
design/line_fill_unit.sv
design/icache_top.sv
verification/mem_model.sv
verification/icache_tb.sv

//--- icache/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,

    input  logic [31:0]         fetch_addr_i,
    input  logic                stall_i,
    output logic [WORD_W-1:0]   instr_o,
    output logic                instr_valid_o,

    output logic                ram_en_o,
    output logic                ram_we_o,
    output logic [INDEX_W-1:0]  ram_index_o,
    output logic [ENTRY_W-1:0]  ram_wdata_o,
    input  logic [ENTRY_W-1:0]  ram_rdata_i,

    output logic                fill_start_o,
    output logic [31:0]         fill_addr_o,
    input  logic                fill_done_i,
    input  logic [LINE_W-1:0]   fill_line_i
);

    logic [STATE_W-1:0]     state_r;
    logic [STATE_W-1:0]     state_nxt;

    fetch_addr_u            cur_addr;
    fetch_addr_u            last_addr_r;
    // set when an address is accepted and cleared when its word was not handed out
    logic                   last_valid_r;

    logic [LINE_COUNT-1:0]  valid_r;

    logic                   new_fetch;
    logic                   addr_current;
    logic                   tag_match;
    logic                   hit;
    logic [TAG_W-1:0]       ram_tag;
    logic [LINE_W-1:0]      ram_line;
    logic [WORD_W-1:0]      hit_word;
    logic [WORD_W-1:0]      fill_word;

    assign cur_addr.raw = fetch_addr_i;

    assign new_fetch    = !stall_i && (!last_valid_r || (fetch_addr_i != last_addr_r.raw));
    assign addr_current = (fetch_addr_i == last_addr_r.raw);

    assign ram_tag   = ram_rdata_i[ENTRY_W-1 -: TAG_W];
    assign ram_line  = ram_rdata_i[LINE_W-1:0];
    assign tag_match = (ram_tag == last_addr_r.f.tag);
    assign hit       = valid_r[last_addr_r.f.index] && tag_match;

    // word offset of the accepted address picks the lane
    assign hit_word  = ram_line[last_addr_r.f.word * WORD_W +: WORD_W];
    assign fill_word = fill_line_i[last_addr_r.f.word * WORD_W +: WORD_W];

    assign instr_o = (state_r == ST_FILL) ? fill_word : hit_word;

    // fill always targets the start of the line
    assign fill_addr_o = {last_addr_r.raw[31:4], 4'b0000};

    always_comb begin
        state_nxt     = state_r;
        ram_en_o      = 1'b0;
        ram_we_o      = 1'b0;
        ram_index_o   = cur_addr.f.index;
        ram_wdata_o   = {last_addr_r.f.tag, fill_line_i};
        instr_valid_o = 1'b0;
        fill_start_o  = 1'b0;

        case (state_r)
            ST_IDLE: begin
                if (new_fetch) begin
                    ram_en_o  = 1'b1;
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (stall_i) begin
                    // keep the read fresh so release can decide at once
                    ram_en_o    = 1'b1;
                    ram_index_o = last_addr_r.f.index;
                end else if (hit) begin
                    instr_valid_o = addr_current;
                    state_nxt     = ST_IDLE;
                end else begin
                    fill_start_o = 1'b1;
                    state_nxt    = ST_FILL;
                end
            end
            ST_FILL: begin
                if (fill_done_i) begin
                    ram_en_o      = 1'b1;
                    ram_we_o      = 1'b1;
                    ram_index_o   = last_addr_r.f.index;
                    instr_valid_o = addr_current && !stall_i;
                    state_nxt     = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_r      <= ST_IDLE;
            last_valid_r <= 1'b0;
            valid_r      <= '0;
        end else begin
            state_r <= state_nxt;

            if (state_r == ST_IDLE && new_fetch) begin
                last_valid_r <= 1'b1;
            end else if (state_r != ST_IDLE && state_nxt == ST_IDLE) begin
                // undelivered word means the same address is looked up again
                last_valid_r <= instr_valid_o;
            end

            if (state_r == ST_FILL && fill_done_i) begin
                valid_r[last_addr_r.f.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_r == ST_IDLE && new_fetch) begin
            last_addr_r <= cur_addr;
        end
    end

    a_done_only_in_fill: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        fill_done_i |-> (state_r == ST_FILL)
    );

endmodule

`default_nettype wire

//--- icache/icache_line_ram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_line_ram import icache_pkg::*; (
    input  logic                clk_i,
    input  logic                en_i,
    input  logic                we_i,
    input  logic [INDEX_W-1:0]  index_i,
    input  logic [ENTRY_W-1:0]  wdata_i,
    output logic [ENTRY_W-1:0]  rdata_o
);

    // tag in the upper bits, line data below
    logic [ENTRY_W-1:0] mem_q [LINE_COUNT];

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[index_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[index_i];
            end
        end
    end

    a_index_in_range: assert property (
        @(posedge clk_i)
        en_i |-> (!$isunknown(index_i) && (int'(index_i) < LINE_COUNT))
    );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module icache_tb -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
else
    exit 1
fi

//--- verification/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int          CLK_NS      = 4;
    localparam logic [31:0] DATA_KEY    = 32'h5a5a_0000;
    localparam int          NUM_RANDOM  = 200;
    localparam int          NUM_FETCHES = NUM_RANDOM + 16;
    // ready stalls plus four beats with the longest gaps
    localparam int          WORST_MISS  = 64;
    localparam int          WAIT_LIMIT  = 4 * WORST_MISS;
    localparam int          WATCHDOG_NS = (NUM_FETCHES * WORST_MISS + 500) * CLK_NS;

    logic        clk_i, rst_i, stall_i, instr_valid_o;
    logic [31:0] fetch_addr_i, instr_o;
    logic        mem_ready_i, mem_req_o, mem_rvalid_i;
    logic [31:0] mem_addr_o, mem_rdata_i;

    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int unsigned req_count = 0;
    int unsigned valid_count = 0;
    int unsigned beat_count = 0;
    integer      seed = 32'h218827bc;

    // expected cache contents by line index
    logic [127:0] shadow_valid;
    logic [20:0]  shadow_tag [128];

    icache_top i_dut (
        .clk_i(clk_i), .rst_i(rst_i),
        .fetch_addr_i(fetch_addr_i), .stall_i(stall_i),
        .instr_o(instr_o), .instr_valid_o(instr_valid_o),
        .mem_ready_i(mem_ready_i), .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
        .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i)
    );

    mem_model #(.DATA_KEY(DATA_KEY), .GAP_MASK(7), .SEED(32'h218827bc)) i_mem (
        .clk_i(clk_i), .rst_i(rst_i),
        .mem_req_i(mem_req_o), .mem_addr_i(mem_addr_o), .mem_ready_o(mem_ready_i),
        .mem_rvalid_o(mem_rvalid_i), .mem_rdata_o(mem_rdata_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            if (mem_req_o) req_count <= req_count + 1;
            if (instr_valid_o) valid_count <= valid_count + 1;
            if (mem_rvalid_i) beat_count <= beat_count + 1;
        end
    end

    function automatic logic [31:0] expected_instr(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ DATA_KEY;
    endfunction

    a_instr_matches_addr: assert property (@(posedge clk_i) disable iff (!rst_i)
        instr_valid_o |-> instr_o == expected_instr(fetch_addr_i))
    else begin
        $display("CHECK FAILED at %0t: instr_o expected %h, got %h", $time,
                 expected_instr($sampled(fetch_addr_i)), $sampled(instr_o));
        errors++;
    end

    a_req_aligned: assert property (@(posedge clk_i) disable iff (!rst_i)
        mem_req_o |-> mem_addr_o == {fetch_addr_i[31:4], 4'h0})
    else begin
        $display("CHECK FAILED at %0t: mem_addr_o expected %h, got %h", $time,
                 {$sampled(fetch_addr_i[31:4]), 4'h0}, $sampled(mem_addr_o));
        errors++;
    end

    a_no_valid_under_stall: assert property (@(posedge clk_i) disable iff (!rst_i)
        stall_i |-> !instr_valid_o)
    else begin
        $display("instr_valid_o pulsed at %0t while stall_i was high", $time);
        errors++;
    end

    task automatic apply_reset();
        rst_i = 1'b0;
        repeat (2) @(negedge clk_i);
        rst_i = 1'b1;
        shadow_valid = '0;
    endtask

    // predicts hit or miss and records the line as cached
    task automatic lookup_shadow(input logic [31:0] addr, output bit miss);
        logic [6:0] idx;
        idx = addr[10:4];
        miss = !shadow_valid[idx] || shadow_tag[idx] != addr[31:11];
        shadow_valid[idx] = 1'b1;
        shadow_tag[idx] = addr[31:11];
    endtask

    task automatic wait_valid(input int unsigned start, input logic [31:0] addr);
        int waited;
        waited = 0;
        while (valid_count == start && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (valid_count == start) begin
            $display("no instruction returned for address %h within %0d cycles", addr,
                     WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic check_requests(input logic [31:0] addr, input int unsigned expected,
                                  input int unsigned actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED at %0t: mem_req_o pulses for %h expected %0d, got %0d",
                     $time, addr, expected, actual);
            errors++;
        end
    endtask

    task automatic fetch(input logic [31:0] addr);
        int unsigned v0;
        int unsigned r0;
        bit          miss;
        lookup_shadow(addr, miss);
        v0 = valid_count;
        r0 = req_count;
        fetch_addr_i = addr;
        wait_valid(v0, addr);
        check_requests(addr, miss ? 1 : 0, req_count - r0);
    endtask

    // stall rises after the request and falls once all four beats are in
    task automatic stalled_fetch(input logic [31:0] addr);
        int unsigned v0;
        int unsigned r0;
        bit          miss;
        int          waited;
        lookup_shadow(addr, miss);
        v0 = valid_count;
        r0 = req_count;
        fetch_addr_i = addr;
        waited = 0;
        while (req_count == r0 && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        stall_i = 1'b1;
        waited = 0;
        while (beat_count < 4 * req_count && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        repeat (4) @(negedge clk_i);
        stall_i = 1'b0;
        wait_valid(v0, addr);
        check_requests(addr, miss ? 1 : 0, req_count - r0);
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) tests_failed++;
        $display("test %-14s %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int          e0;
        logic [31:0] addr;
        logic [31:0] prev;
        rst_i = 1'b0;
        stall_i = 1'b0;
        fetch_addr_i = 32'h0;
        apply_reset();

        e0 = errors;
        fetch(32'h0000_0000);
        end_test("cold_miss", e0);

        e0 = errors;
        fetch(32'h0000_0004);
        fetch(32'h0000_0008);
        fetch(32'h0000_000f);
        end_test("line_hit", e0);

        // index 16 with tags 0 and 1
        e0 = errors;
        for (int i = 0; i < 3; i++) begin
            fetch(32'h0000_0104);
            fetch(32'h0000_0904);
        end
        end_test("conflict", e0);

        e0 = errors;
        stalled_fetch(32'h0000_2048);
        end_test("stall", e0);

        e0 = errors;
        apply_reset();
        fetch(32'h0000_0000);
        end_test("reset_invalid", e0);

        // 4 KB region is twice the cache size
        e0 = errors;
        prev = fetch_addr_i;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            do begin
                addr = 32'h0000_4000 | ($random(seed) & 32'h0000_0fff);
            end while (addr == prev);
            fetch(addr);
            prev = addr;
        end
        end_test("random_stream", e0);

        $display("tests run: %0d, tests failed: %0d, check errors: %0d, requests: %0d",
                 tests_run, tests_failed, errors, req_count);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
    parameter logic [31:0] DATA_KEY = 32'h5a5a_0000,
    parameter int          GAP_MASK = 7,
    parameter int          SEED     = 32'h218827bc
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        mem_req_i,
    input  logic [31:0] mem_addr_i,
    output logic        mem_ready_o,
    output logic        mem_rvalid_o,
    output logic [31:0] mem_rdata_o
);

    int unsigned req_seen = 0;
    int unsigned req_served = 0;
    logic [31:0] line_addr;
    integer      seed;

    always @(posedge clk_i) begin
        if (rst_i && mem_req_i) begin
            req_seen  <= req_seen + 1;
            line_addr <= mem_addr_i;
        end
    end

    // one line at a time, four beats with random gaps
    initial begin
        bit active;
        int beat;
        int gap;
        seed = SEED;
        active = 1'b0;
        beat = 0;
        gap = 0;
        mem_ready_o = 1'b1;
        mem_rvalid_o = 1'b0;
        mem_rdata_o = '0;
        forever begin
            @(negedge clk_i);
            mem_rvalid_o = 1'b0;
            // ready drops about one cycle in four
            mem_ready_o = ($random(seed) & 3) != 0;
            if (!active) begin
                if (req_served != req_seen) begin
                    req_served = req_seen;
                    active = 1'b1;
                    beat = 0;
                    gap = $random(seed) & GAP_MASK;
                end
            end else if (gap > 0) begin
                gap--;
            end else begin
                mem_rvalid_o = 1'b1;
                mem_rdata_o = (line_addr + 32'(4 * beat)) ^ DATA_KEY;
                beat++;
                if (beat == 4) begin
                    active = 1'b0;
                end else begin
                    gap = $random(seed) & GAP_MASK;
                end
            end
        end
    end

endmodule

`default_nettype wire
